//--- include/vfu_settings.svh
/*
 * Vector integer execution unit settings
 * Lane count, register-file geometry and the id and length widths
 */

`ifndef VFU_SETTINGS_SVH
`define VFU_SETTINGS_SVH

// Number of 32-bit lanes in one register-file word
`define VFU_N_LANES 2

// Lane width in bits
`define VFU_ELEN 32

// Register file geometry
`define VFU_NR_VREGS 32
`define VFU_WORDS_PER_VREG 4

// Derived register-file widths
`define VFU_VREG_W ($clog2(`VFU_NR_VREGS))
`define VFU_WIDX_W ($clog2(`VFU_WORDS_PER_VREG))
`define VFU_ADDR_W ($clog2(`VFU_NR_VREGS * `VFU_WORDS_PER_VREG))

// Instruction id width
`define VFU_ID_W 3

// Vector length counter, holds up to a full register of bytes
`define VFU_VL_W 6

`endif

//--- list.f
+incdir+include
rtl/vfu_isa_pkg.sv
rtl/vfu_data_pkg.sv
rtl/vfu_operation_queue.sv
rtl/vfu_sequencer.sv
rtl/vfu_int_lane.sv
rtl/vfu_writeback.sv
rtl/vfu_top.sv
verif/vfu_assert.sv
verif/vfu_tb.sv

//--- rtl/vfu_data_pkg.sv
/*
 * Vector execution unit datapath types
 * Lane word, register-file addressing, pipeline tag and response
 */

`default_nettype none

`include "vfu_settings.svh"

package vfu_data_pkg;

  // One lane word, decoded by the element width
  typedef union packed {
    logic [`VFU_ELEN/8-1:0][7:0]   b;
    logic [`VFU_ELEN/16-1:0][15:0] h;
    logic [`VFU_ELEN-1:0]          w;
  } lane_word_u;

  // Register number times words per register plus word index
  typedef logic [`VFU_ADDR_W-1:0] vreg_addr_t;

  typedef lane_word_u [`VFU_N_LANES-1:0] vreg_word_t;

  typedef logic [`VFU_ELEN/8*`VFU_N_LANES-1:0] vreg_be_t;

  // Travels with each word through the lane pipeline
  typedef struct packed {
    vfu_isa_pkg::id_t  id;
    vreg_addr_t        waddr;
    vfu_isa_pkg::sew_e sew;
    // Elements still to be written, this word included
    vfu_isa_pkg::vl_t  rem;
    logic              last;
    logic              is_scalar;
  } vfu_tag_t;

  typedef struct packed {
    vfu_isa_pkg::id_t     id;
    logic                 is_scalar;
    logic [`VFU_ELEN-1:0] result;
  } vfu_rsp_t;

  // Elements held by one register-file word
  function automatic vfu_isa_pkg::vl_t elems_per_word(vfu_isa_pkg::sew_e sew);
    return vfu_isa_pkg::vl_t'((`VFU_ELEN / 8 * `VFU_N_LANES) >> sew);
  endfunction

endpackage

`default_nettype wire

//--- rtl/vfu_int_lane.sv
/*
 * SIMD integer lane
 * Two-stage pipeline over one 32-bit lane word, split into bytes,
 * halfwords or a word by the element width
 */

`default_nettype none
`timescale 1ns/10ps

`include "vfu_settings.svh"

module vfu_int_lane (
  input  wire                             clk_i,
  input  wire                             reset_i,
  input  wire                             issue_i,
  input  wire vfu_isa_pkg::op_e           op_i,
  input  wire vfu_isa_pkg::sew_e          sew_i,
  input  wire vfu_data_pkg::lane_word_u   opa_i,
  input  wire vfu_data_pkg::lane_word_u   opb_i,
  input  wire vfu_data_pkg::vfu_tag_t     tag_i,
  output vfu_data_pkg::lane_word_u        result_o,
  output logic                            result_valid_o,
  output vfu_data_pkg::vfu_tag_t          tag_o
);

  logic                     valid_q;
  vfu_isa_pkg::op_e         op_q;
  vfu_isa_pkg::sew_e        sew_q;
  vfu_data_pkg::lane_word_u opa_q;
  vfu_data_pkg::lane_word_u opb_q;
  vfu_data_pkg::vfu_tag_t   tag_q;
  vfu_data_pkg::lane_word_u result_d;

  // Narrow elements come in zero-extended, so the caller's truncation
  // keeps carries and compares inside the element
  function automatic logic [`VFU_ELEN-1:0] alu(vfu_isa_pkg::op_e op,
                                               logic [`VFU_ELEN-1:0] a,
                                               logic [`VFU_ELEN-1:0] b);
    case (op)
      vfu_isa_pkg::OP_ADD:  return b + a;
      // vs2 minus vs1
      vfu_isa_pkg::OP_SUB:  return b - a;
      vfu_isa_pkg::OP_AND:  return b & a;
      vfu_isa_pkg::OP_OR:   return b | a;
      vfu_isa_pkg::OP_XOR:  return b ^ a;
      vfu_isa_pkg::OP_MINU: return (a < b) ? a : b;
      vfu_isa_pkg::OP_MAXU: return (a > b) ? a : b;
      default:              return '0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stage 1 operand registers

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issue_i;
    end
  end

  always_ff @(posedge clk_i) begin
    op_q  <= op_i;
    sew_q <= sew_i;
    opa_q <= opa_i;
    opb_q <= opb_i;
    tag_q <= tag_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage 2 compute and result registers

  always_comb begin
    result_d = '0;
    case (sew_q)
      vfu_isa_pkg::SEW_8: begin
        for (int i = 0; i < `VFU_ELEN / 8; i++) begin
          result_d.b[i] = 8'(alu(op_q, `VFU_ELEN'(opa_q.b[i]), `VFU_ELEN'(opb_q.b[i])));
        end
      end
      vfu_isa_pkg::SEW_16: begin
        for (int i = 0; i < `VFU_ELEN / 16; i++) begin
          result_d.h[i] = 16'(alu(op_q, `VFU_ELEN'(opa_q.h[i]), `VFU_ELEN'(opb_q.h[i])));
        end
      end
      default: result_d.w = alu(op_q, opa_q.w, opb_q.w);
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    result_o <= result_d;
    tag_o    <= tag_q;
  end

endmodule

`default_nettype wire

//--- rtl/vfu_isa_pkg.sv
/*
 * Vector execution unit instruction types
 * Opcodes, element widths and the request handed to the unit
 */

`default_nettype none

`include "vfu_settings.svh"

package vfu_isa_pkg;

  typedef logic [`VFU_ID_W-1:0]   id_t;
  typedef logic [`VFU_VL_W-1:0]   vl_t;
  typedef logic [`VFU_VREG_W-1:0] vreg_t;

  // Integer operations of the lane
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_XOR  = 3'd4,
    OP_MINU = 3'd5,
    OP_MAXU = 3'd6
  } op_e;

  // Encoded as log2 of the element bytes
  typedef enum logic [1:0] {
    SEW_8  = 2'd0,
    SEW_16 = 2'd1,
    SEW_32 = 2'd2
  } sew_e;

  typedef struct packed {
    id_t                  id;
    op_e                  op;
    sew_e                 sew;
    vl_t                  vl;
    vreg_t                vd;
    vreg_t                vs1;
    vreg_t                vs2;
    logic [`VFU_ELEN-1:0] rs1;
    // Second scalar operand, only read by the scalar form
    logic [`VFU_ELEN-1:0] rs2;
    logic                 use_vs1;
    logic                 use_vs2;
    logic                 is_scalar;
  } vfu_req_t;

endpackage

`default_nettype wire

//--- rtl/vfu_operation_queue.sv
/*
 * Operation queue
 * Two-entry spill register between the request handshake and issue
 */

`default_nettype none
`timescale 1ns/10ps

module vfu_operation_queue (
  input  wire                           clk_i,
  input  wire                           reset_i,
  input  wire vfu_isa_pkg::vfu_req_t    req_i,
  input  wire                           req_valid_i,
  output logic                          req_ready_o,
  output vfu_isa_pkg::vfu_req_t         head_req_o,
  output logic                          head_valid_o,
  input  wire                           pop_i
);

  vfu_isa_pkg::vfu_req_t entry_q [2];
  logic                  wr_ptr_q;
  logic                  rd_ptr_q;
  logic [1:0]            count_q;
  logic                  push;

  // Room while fewer than two entries are held
  assign req_ready_o  = (count_q != 2'd2);
  assign push         = req_valid_i && req_ready_o;

  assign head_valid_o = (count_q != 2'd0);
  assign head_req_o   = entry_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop_i) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_q + 2'(push) - 2'(pop_i);
    end
  end

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      entry_q[wr_ptr_q] <= req_i;
    end
  end

endmodule

`default_nettype wire

//--- rtl/vfu_sequencer.sv
/*
 * Word sequencer
 * Walks the vector one register-file word at a time, requests the
 * source words, builds the operands and the tag, and pops the queue
 * on the last word of each instruction
 */

`default_nettype none
`timescale 1ns/10ps

`include "vfu_settings.svh"

module vfu_sequencer (
  input  wire                                clk_i,
  input  wire                                reset_i,
  input  wire vfu_isa_pkg::vfu_req_t         head_req_i,
  input  wire                                head_valid_i,
  output logic                               pop_o,
  output vfu_data_pkg::vreg_addr_t [2:0]     vrf_raddr_o,
  output logic [2:0]                         vrf_re_o,
  input  wire vfu_data_pkg::vreg_word_t [2:0] vrf_rdata_i,
  input  wire [2:0]                          vrf_rvalid_i,
  output logic [`VFU_N_LANES-1:0]            issue_o,
  output vfu_isa_pkg::op_e                   op_o,
  output vfu_isa_pkg::sew_e                  sew_o,
  output vfu_data_pkg::vreg_word_t           opa_o,
  output vfu_data_pkg::vreg_word_t           opb_o,
  output vfu_data_pkg::vfu_tag_t             tag_o
);

  vfu_isa_pkg::vl_t        done_q;
  logic [`VFU_WIDX_W-1:0]  widx_q;
  vfu_isa_pkg::vl_t        epw;
  vfu_isa_pkg::vl_t        rem;
  logic                    last;
  logic                    go;

  function automatic vfu_data_pkg::vreg_addr_t word_addr(vfu_isa_pkg::vreg_t vreg,
                                                         logic [`VFU_WIDX_W-1:0] widx);
    return vfu_data_pkg::vreg_addr_t'(vreg * `VFU_WORDS_PER_VREG + widx);
  endfunction

  assign epw  = vfu_data_pkg::elems_per_word(head_req_i.sew);
  assign rem  = head_req_i.vl - done_q;
  // Scalar form is always a single word
  assign last = head_req_i.is_scalar || (rem <= epw);

  ////////////////////////////////////////////////////////////////////////////
  // Register-file reads

  // Port 0 is vs2, port 1 is vs1, port 2 (vd) is never a source here
  assign vrf_re_o = (head_valid_i && !head_req_i.is_scalar) ?
                    {1'b0, head_req_i.use_vs1, head_req_i.use_vs2} : 3'b000;

  assign vrf_raddr_o[0] = word_addr(head_req_i.vs2, widx_q);
  assign vrf_raddr_o[1] = word_addr(head_req_i.vs1, widx_q);
  assign vrf_raddr_o[2] = word_addr(head_req_i.vd, widx_q);

  // Issue once every requested operand is there
  assign go    = head_valid_i && (&(vrf_rvalid_i | ~vrf_re_o));
  assign pop_o = go && last;

  ////////////////////////////////////////////////////////////////////////////
  // Issue to the lanes

  // Only lane 0 runs a scalar instruction
  assign issue_o = !go                  ? '0 :
                   head_req_i.is_scalar ? `VFU_N_LANES'(1) : '1;

  assign op_o  = head_req_i.op;
  assign sew_o = head_req_i.sew;

  always_comb begin
    if (head_req_i.is_scalar) begin
      opa_o = {`VFU_N_LANES{head_req_i.rs1}};
      opb_o = {`VFU_N_LANES{head_req_i.rs2}};
    end else begin
      opb_o = vrf_rdata_i[0];
      if (head_req_i.use_vs1) begin
        opa_o = vrf_rdata_i[1];
      end else begin
        // Broadcast rs1 into every element
        case (head_req_i.sew)
          vfu_isa_pkg::SEW_8:  opa_o = {(`VFU_ELEN / 8 * `VFU_N_LANES){head_req_i.rs1[7:0]}};
          vfu_isa_pkg::SEW_16: opa_o = {(`VFU_ELEN / 16 * `VFU_N_LANES){head_req_i.rs1[15:0]}};
          default:             opa_o = {`VFU_N_LANES{head_req_i.rs1}};
        endcase
      end
    end
  end

  assign tag_o = '{
    id:        head_req_i.id,
    waddr:     vrf_raddr_o[2],
    sew:       head_req_i.sew,
    rem:       rem,
    last:      last,
    is_scalar: head_req_i.is_scalar
  };

  // Element counter and word index
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      done_q <= '0;
      widx_q <= '0;
    end else if (go) begin
      if (last) begin
        done_q <= '0;
        widx_q <= '0;
      end else begin
        done_q <= done_q + epw;
        widx_q <= widx_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/vfu_top.sv
/*
 * Vector integer execution unit
 * Operation queue, word sequencer, SIMD lanes and writeback
 */

`default_nettype none
`timescale 1ns/10ps

`include "vfu_settings.svh"

module vfu_top (
  input  wire                                 clk_i,
  input  wire                                 reset_i,
  input  wire vfu_isa_pkg::vfu_req_t          req_i,
  input  wire                                 req_valid_i,
  output logic                                req_ready_o,
  output vfu_data_pkg::vreg_addr_t [2:0]      vrf_raddr_o,
  output logic [2:0]                          vrf_re_o,
  input  wire vfu_data_pkg::vreg_word_t [2:0] vrf_rdata_i,
  input  wire [2:0]                           vrf_rvalid_i,
  output logic                                vrf_we_o,
  output vfu_data_pkg::vreg_addr_t            vrf_waddr_o,
  output vfu_data_pkg::vreg_word_t            vrf_wdata_o,
  output vfu_data_pkg::vreg_be_t              vrf_wbe_o,
  output logic                                rsp_valid_o,
  output vfu_data_pkg::vfu_rsp_t              rsp_o
);

  vfu_isa_pkg::vfu_req_t                       head_req;
  logic                                        head_valid;
  logic                                        pop;
  logic [`VFU_N_LANES-1:0]                     issue;
  vfu_isa_pkg::op_e                            op;
  vfu_isa_pkg::sew_e                           sew;
  vfu_data_pkg::vreg_word_t                    opa;
  vfu_data_pkg::vreg_word_t                    opb;
  vfu_data_pkg::vfu_tag_t                      seq_tag;
  vfu_data_pkg::vreg_word_t                    lane_result;
  logic [`VFU_N_LANES-1:0]                     lane_valid;
  vfu_data_pkg::vfu_tag_t [`VFU_N_LANES-1:0]   lane_tag;

  vfu_operation_queue u_queue (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .head_req_o   (head_req),
    .head_valid_o (head_valid),
    .pop_i        (pop)
  );

  vfu_sequencer u_sequencer (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .head_req_i   (head_req),
    .head_valid_i (head_valid),
    .pop_o        (pop),
    .vrf_raddr_o  (vrf_raddr_o),
    .vrf_re_o     (vrf_re_o),
    .vrf_rdata_i  (vrf_rdata_i),
    .vrf_rvalid_i (vrf_rvalid_i),
    .issue_o      (issue),
    .op_o         (op),
    .sew_o        (sew),
    .opa_o        (opa),
    .opb_o        (opb),
    .tag_o        (seq_tag)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Lanes, all fed the same tag

  for (genvar l = 0; l < `VFU_N_LANES; l++) begin : gen_lanes
    vfu_int_lane u_lane (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .issue_i        (issue[l]),
      .op_i           (op),
      .sew_i          (sew),
      .opa_i          (opa[l]),
      .opb_i          (opb[l]),
      .tag_i          (seq_tag),
      .result_o       (lane_result[l]),
      .result_valid_o (lane_valid[l]),
      .tag_o          (lane_tag[l])
    );
  end

  // Lane 0 is valid for both vector and scalar words
  vfu_writeback u_writeback (
    .lane_result_i (lane_result),
    .lane_valid_i  (lane_valid[0]),
    .tag_i         (lane_tag[0]),
    .vrf_we_o      (vrf_we_o),
    .vrf_waddr_o   (vrf_waddr_o),
    .vrf_wdata_o   (vrf_wdata_o),
    .vrf_wbe_o     (vrf_wbe_o),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_o         (rsp_o)
  );

endmodule

`default_nettype wire

//--- rtl/vfu_writeback.sv
/*
 * Writeback
 * Byte enables for the trailing word, register-file write and the
 * completion response
 */

`default_nettype none
`timescale 1ns/10ps

`include "vfu_settings.svh"

module vfu_writeback (
  input  wire vfu_data_pkg::vreg_word_t lane_result_i,
  input  wire                           lane_valid_i,
  input  wire vfu_data_pkg::vfu_tag_t   tag_i,
  output logic                          vrf_we_o,
  output vfu_data_pkg::vreg_addr_t      vrf_waddr_o,
  output vfu_data_pkg::vreg_word_t      vrf_wdata_o,
  output vfu_data_pkg::vreg_be_t        vrf_wbe_o,
  output logic                          rsp_valid_o,
  output vfu_data_pkg::vfu_rsp_t        rsp_o
);

  vfu_isa_pkg::vl_t       epw;
  vfu_isa_pkg::vl_t       nelem;
  logic [`VFU_VL_W+1:0]   nbytes;
  vfu_data_pkg::vreg_be_t be;

  // Elements of this word that still fall below vl
  assign epw    = vfu_data_pkg::elems_per_word(tag_i.sew);
  assign nelem  = (tag_i.rem > epw) ? epw : tag_i.rem;
  assign nbytes = {2'b00, nelem} << tag_i.sew;

  // Low bytes enabled and the tail past vl left alone
  assign be = ~(vfu_data_pkg::vreg_be_t'('1) << nbytes);

  ////////////////////////////////////////////////////////////////////////////
  // Register-file write

  assign vrf_we_o    = lane_valid_i && !tag_i.is_scalar;
  assign vrf_waddr_o = tag_i.waddr;
  assign vrf_wdata_o = lane_result_i;
  assign vrf_wbe_o   = vrf_we_o ? be : '0;

  ////////////////////////////////////////////////////////////////////////////
  // Completion response

  assign rsp_valid_o = lane_valid_i && tag_i.last;

  assign rsp_o = '{
    id:        tag_i.id,
    is_scalar: tag_i.is_scalar,
    result:    tag_i.is_scalar ? lane_result_i[0].w : '0
  };

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the vector execution unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert \
  --top-module vfu_tb \
  -f list.f \
  -o vfu_sim

./obj_dir/vfu_sim

//--- verif/vfu_assert.sv
/*
 * Protocol assertions for the vector execution unit
 * Write strobe under reset, write byte enables and response spacing
 */

`default_nettype none
`timescale 1ns/10ps

module vfu_assert (
  input wire                         clk_i,
  input wire                         reset_i,
  input wire                         req_valid_i,
  input wire                         req_ready_o,
  input wire                         vrf_we_o,
  input wire vfu_data_pkg::vreg_be_t vrf_wbe_o,
  input wire                         rsp_valid_o
);

  // Instructions accepted and not yet answered
  logic [3:0] inflight_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      inflight_q <= '0;
    end else begin
      inflight_q <= inflight_q + 4'(req_valid_i && req_ready_o) - 4'(rsp_valid_o);
    end
  end

  no_write_in_reset: assert property (@(posedge clk_i)
    (reset_i && $past(reset_i)) |-> !vrf_we_o)
    else $error("register-file write during reset");

  write_has_bytes: assert property (@(posedge clk_i) disable iff (reset_i)
    vrf_we_o |-> (vrf_wbe_o != '0))
    else $error("register-file write with no byte enabled");

  // A second pulse right after the first needs another instruction
  rsp_pulse_spacing: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_o |=> (!rsp_valid_o || inflight_q != '0))
    else $error("two responses in a row for a single instruction");

endmodule

bind vfu_top vfu_assert u_assert (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .req_valid_i (req_valid_i),
  .req_ready_o (req_ready_o),
  .vrf_we_o    (vrf_we_o),
  .vrf_wbe_o   (vrf_wbe_o),
  .rsp_valid_o (rsp_valid_o)
);

`default_nettype wire

//--- verif/vfu_tb.sv
/*
 * Testbench for the vector integer execution unit
 * Register-file model with random read stalls, reference model and
 * a response and destination checker
 */

`default_nettype none
`timescale 1ns/10ps

`include "vfu_settings.svh"

module vfu_tb;

  localparam int WORD_W = `VFU_ELEN * `VFU_N_LANES;
  localparam int NWORDS = `VFU_NR_VREGS * `VFU_WORDS_PER_VREG;
  localparam int WPR    = `VFU_WORDS_PER_VREG;

  // Expected outcome of one instruction
  typedef struct {
    string             name;
    vfu_isa_pkg::id_t  id;
    logic              is_scalar;
    logic [31:0]       result;
    int                vd;
    logic [WORD_W-1:0] words [WPR];
  } expect_t;

  logic                                clk_i;
  logic                                reset_i;
  vfu_isa_pkg::vfu_req_t               req_i;
  logic                                req_valid_i;
  logic                                req_ready_o;
  logic [2:0][`VFU_ADDR_W-1:0]         vrf_raddr_o;
  logic [2:0]                          vrf_re_o;
  logic [2:0][WORD_W-1:0]              vrf_rdata_i;
  logic [2:0]                          vrf_rvalid_i;
  logic                                vrf_we_o;
  logic [`VFU_ADDR_W-1:0]              vrf_waddr_o;
  logic [WORD_W-1:0]                   vrf_wdata_o;
  logic [WORD_W/8-1:0]                 vrf_wbe_o;
  logic                                rsp_valid_o;
  vfu_data_pkg::vfu_rsp_t              rsp_o;

  logic [WORD_W-1:0] mem [NWORDS];
  integer            seed;
  expect_t           exp_q [$];
  expect_t           pend;
  logic              mem_pending;
  vfu_isa_pkg::id_t  next_id;

  vfu_top dut0 (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .vrf_raddr_o  (vrf_raddr_o),
    .vrf_re_o     (vrf_re_o),
    .vrf_rdata_i  (vrf_rdata_i),
    .vrf_rvalid_i (vrf_rvalid_i),
    .vrf_we_o     (vrf_we_o),
    .vrf_waddr_o  (vrf_waddr_o),
    .vrf_wdata_o  (vrf_wdata_o),
    .vrf_wbe_o    (vrf_wbe_o),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register-file model

  // Ports that are not requested return zeros
  always_comb begin
    for (int k = 0; k < 3; k++) begin
      vrf_rdata_i[k] = vrf_re_o[k] ? mem[vrf_raddr_o[k]] : '0;
    end
  end

  always @(posedge clk_i) begin
    if (vrf_we_o) begin
      for (int b = 0; b < WORD_W / 8; b++) begin
        if (vrf_wbe_o[b]) begin
          mem[vrf_waddr_o][b*8 +: 8] <= vrf_wdata_o[b*8 +: 8];
        end
      end
    end
  end

  // Roughly one stall in four per port
  always @(posedge clk_i) begin
    if (reset_i) begin
      vrf_rvalid_i <= 3'b111;
    end else begin
      for (int k = 0; k < 3; k++) begin
        vrf_rvalid_i[k] <= (($random(seed) & 3) != 0);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model

  function automatic logic [31:0] elem_op(vfu_isa_pkg::op_e op, logic [31:0] a,
                                          logic [31:0] b);
    case (op)
      vfu_isa_pkg::OP_ADD:  return b + a;
      vfu_isa_pkg::OP_SUB:  return b - a;
      vfu_isa_pkg::OP_AND:  return b & a;
      vfu_isa_pkg::OP_OR:   return b | a;
      vfu_isa_pkg::OP_XOR:  return b ^ a;
      vfu_isa_pkg::OP_MINU: return (a < b) ? a : b;
      vfu_isa_pkg::OP_MAXU: return (a > b) ? a : b;
      default:              return 32'h0;
    endcase
  endfunction

  // Expected word widx of vd
  // Elements at or past vl keep the old bytes
  function automatic logic [WORD_W-1:0] vfu_ref(vfu_isa_pkg::vfu_req_t r, int widx,
                                                logic [WORD_W-1:0] vs2w,
                                                logic [WORD_W-1:0] vs1w,
                                                logic [WORD_W-1:0] oldw);
    int                ebits;
    int                epw;
    logic [31:0]       m;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [31:0]       y;
    logic [WORD_W-1:0] res;
    ebits = 8 << r.sew;
    epw   = WORD_W / ebits;
    m     = (ebits == 32) ? 32'hffff_ffff : ((32'd1 << ebits) - 32'd1);
    res   = oldw;
    if (!r.is_scalar) begin
      for (int j = 0; j < epw; j++) begin
        if (widx * epw + j < int'(r.vl)) begin
          a   = r.use_vs1 ? (32'(vs1w >> (j * ebits)) & m) : (r.rs1 & m);
          b   = 32'(vs2w >> (j * ebits)) & m;
          y   = elem_op(r.op, a, b) & m;
          res = (res & ~(WORD_W'(m) << (j * ebits))) | (WORD_W'(y) << (j * ebits));
        end
      end
    end
    return res;
  endfunction

  function automatic logic [31:0] scalar_ref(vfu_isa_pkg::vfu_req_t r);
    int          ebits;
    logic [31:0] m;
    logic [31:0] y;
    logic [31:0] res;
    ebits = 8 << r.sew;
    m     = (ebits == 32) ? 32'hffff_ffff : ((32'd1 << ebits) - 32'd1);
    res   = 32'h0;
    for (int j = 0; j < 32 / ebits; j++) begin
      y   = elem_op(r.op, (r.rs1 >> (j * ebits)) & m, (r.rs2 >> (j * ebits)) & m) & m;
      res = res | (y << (j * ebits));
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting and checker

  task automatic value_error(string name, string what, logic [WORD_W-1:0] expv,
                             logic [WORD_W-1:0] actv);
    $display("Error in %s: %s expected %h, actual %h", name, what, expv, actv);
    $display("Simulation failed");
    $fatal(1, "value mismatch");
  endtask

  task automatic protocol_error(string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "protocol error");
  endtask

  // Outputs are sampled mid-cycle and the destination one cycle after the response
  always @(negedge clk_i) begin
    if (!reset_i) begin
      assert (vrf_re_o[2] == 1'b0)
        else value_error("read ports", "vd read enable", WORD_W'(1'b0),
                         WORD_W'(vrf_re_o[2]));
      if (mem_pending) begin
        for (int w = 0; w < WPR; w++) begin
          assert (mem[pend.vd * WPR + w] == pend.words[w])
            else value_error(pend.name, $sformatf("vd word %0d", w), pend.words[w],
                             mem[pend.vd * WPR + w]);
        end
        mem_pending = 1'b0;
      end
      if (rsp_valid_o) begin
        assert (exp_q.size() != 0)
          else protocol_error("A response came out with no instruction outstanding");
        pend = exp_q.pop_front();
        assert (rsp_o.id == pend.id)
          else value_error(pend.name, "response id", WORD_W'(pend.id), WORD_W'(rsp_o.id));
        assert (rsp_o.is_scalar == pend.is_scalar)
          else value_error(pend.name, "response is_scalar", WORD_W'(pend.is_scalar),
                           WORD_W'(rsp_o.is_scalar));
        assert (rsp_o.result == pend.result)
          else value_error(pend.name, "response result", WORD_W'(pend.result),
                           WORD_W'(rsp_o.result));
        mem_pending = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus

  task automatic issue_req(string name, vfu_isa_pkg::op_e op, vfu_isa_pkg::sew_e sew,
                           int vl, int vd, int vs1, int vs2, logic [31:0] rs1,
                           logic [31:0] rs2, logic use_vs1, logic is_scalar);
    vfu_isa_pkg::vfu_req_t r;
    expect_t               e;
    r           = '0;
    r.id        = next_id;
    r.op        = op;
    r.sew       = sew;
    r.vl        = vfu_isa_pkg::vl_t'(vl);
    r.vd        = vfu_isa_pkg::vreg_t'(vd);
    r.vs1       = vfu_isa_pkg::vreg_t'(vs1);
    r.vs2       = vfu_isa_pkg::vreg_t'(vs2);
    r.rs1       = rs1;
    r.rs2       = rs2;
    r.use_vs1   = use_vs1 && !is_scalar;
    r.use_vs2   = !is_scalar;
    r.is_scalar = is_scalar;
    e.name      = name;
    e.id        = next_id;
    e.is_scalar = is_scalar;
    e.result    = is_scalar ? scalar_ref(r) : 32'h0;
    e.vd        = vd;
    for (int w = 0; w < WPR; w++) begin
      e.words[w] = vfu_ref(r, w, mem[vs2 * WPR + w], mem[vs1 * WPR + w], mem[vd * WPR + w]);
    end
    next_id = next_id + 1'b1;
    @(posedge clk_i);
    req_i       <= r;
    req_valid_i <= 1'b1;
    @(negedge clk_i);
    while (!req_ready_o) begin
      @(negedge clk_i);
    end
    exp_q.push_back(e);
    @(posedge clk_i);
    req_valid_i <= 1'b0;
  endtask

  task automatic wait_done();
    @(negedge clk_i);
    while (exp_q.size() != 0 || mem_pending) begin
      @(negedge clk_i);
    end
  endtask

  task automatic run_vec(string name, vfu_isa_pkg::op_e op, vfu_isa_pkg::sew_e sew,
                         int vl, int vd, logic [31:0] rs1, logic use_vs1);
    issue_req(name, op, sew, vl, vd, 2, 1, rs1, 32'h0, use_vs1, 1'b0);
    wait_done();
  endtask

  // Watchdog at about ten times the expected run
  initial begin
    repeat (4000) @(posedge clk_i);
    $display("Simulation failed");
    $fatal(1, "Timeout: the tests did not finish within 4000 cycles");
  end

  initial begin
    seed        = 57;
    reset_i     = 1'b1;
    req_i       = '0;
    req_valid_i = 1'b0;
    vrf_rvalid_i = 3'b111;
    mem_pending = 1'b0;
    next_id     = '0;
    for (int a = 0; a < NWORDS; a++) begin
      mem[a] = {32'(a) * 32'h9e37_79b1, (32'(a) * 32'h85eb_ca6b) ^ 32'hc3a5_5a3c};
    end
    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;
    repeat (2) @(posedge clk_i);

    // Every op on full 32-bit registers
    for (int o = 0; o < 7; o++) begin
      run_vec($sformatf("sew32 op %0d", o), vfu_isa_pkg::op_e'(o), vfu_isa_pkg::SEW_32,
              8, 8 + o, 32'h0, 1'b1);
    end

    // Narrow add and subtract
    run_vec("sew8 add", vfu_isa_pkg::OP_ADD, vfu_isa_pkg::SEW_8, 32, 16, 32'h0, 1'b1);
    run_vec("sew8 sub", vfu_isa_pkg::OP_SUB, vfu_isa_pkg::SEW_8, 32, 17, 32'h0, 1'b1);
    run_vec("sew16 add", vfu_isa_pkg::OP_ADD, vfu_isa_pkg::SEW_16, 16, 18, 32'h0, 1'b1);
    run_vec("sew16 sub", vfu_isa_pkg::OP_SUB, vfu_isa_pkg::SEW_16, 16, 19, 32'h0, 1'b1);

    // Partial last word
    run_vec("tail sew8", vfu_isa_pkg::OP_XOR, vfu_isa_pkg::SEW_8, 13, 20, 32'h0, 1'b1);
    run_vec("tail sew16", vfu_isa_pkg::OP_ADD, vfu_isa_pkg::SEW_16, 5, 21, 32'h0, 1'b1);
    run_vec("tail sew32", vfu_isa_pkg::OP_MAXU, vfu_isa_pkg::SEW_32, 3, 22, 32'h0, 1'b1);

    // Scalar rs1 broadcast as operand a
    run_vec("bcast sew8", vfu_isa_pkg::OP_ADD, vfu_isa_pkg::SEW_8, 32, 23, 32'h89ab_cdef,
            1'b0);
    run_vec("bcast sew16", vfu_isa_pkg::OP_SUB, vfu_isa_pkg::SEW_16, 16, 24, 32'h89ab_cdef,
            1'b0);
    run_vec("bcast sew32", vfu_isa_pkg::OP_MINU, vfu_isa_pkg::SEW_32, 8, 25, 32'h89ab_cdef,
            1'b0);

    // Scalar form answers in the response and leaves vd as it was
    issue_req("scalar add", vfu_isa_pkg::OP_ADD, vfu_isa_pkg::SEW_32, 1, 26, 0, 0,
              32'hffff_fff0, 32'h0000_0123, 1'b0, 1'b1);
    wait_done();
    issue_req("scalar maxu", vfu_isa_pkg::OP_MAXU, vfu_isa_pkg::SEW_8, 1, 27, 0, 0,
              32'h10f0_7f01, 32'h8008_7e02, 1'b0, 1'b1);
    wait_done();

    // Independent instructions back to back under read stalls
    // vl stays within one register at each element width
    for (int i = 0; i < 6; i++) begin
      issue_req($sformatf("burst %0d", i), vfu_isa_pkg::op_e'(i), vfu_isa_pkg::sew_e'(i % 3),
                1 + (3 + 5 * i) % (32 >> (i % 3)), 28 + (i % 4), 3, 4, 32'h0, 32'h0, 1'b1,
                1'b0);
      if (i == 3) begin
        wait_done();
      end
    end
    wait_done();

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire
